//--- sim.f
hw/regmap_pkg.sv
hw/cond_pkg.sv
hw/axil_reg_bank.sv
hw/pattern_gen.sv
hw/cap_sequencer.sv
hw/mode_select.sv
hw/cond_ctrl_top.sv
verification/tb_cond_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with verilator, the log decides pass or fail
LOG=sim.log

rm -rf obj_dir "$LOG"

{ verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_cond_ctrl \
    -o tb_cond_ctrl && ./obj_dir/tb_cond_ctrl; } > "$LOG" 2>&1 ||
  echo "CHECKS FAILED" >> "$LOG"

cat "$LOG"

grep -q "CHECKS FAILED" "$LOG" && exit 1
grep -q "ALL CHECKS PASSED" "$LOG" || exit 1
exit 0

//--- verification/tb_cond_ctrl.sv
/*
 * testbench for the conditioning output controller
 * AXI4-Lite bus tasks, typed compare tasks, register table,
 * pattern, capacitor sequence and back-pressure checks
 */

module tb_cond_ctrl;

  timeunit 1ns;
  timeprecision 100ps;

  // table layout with fixed entries first and the random direct writes after
  localparam int NUM_FIXED      = 12;
  localparam int NUM_DIRECT     = 4;
  localparam int NUM_ENTRIES    = NUM_FIXED + NUM_DIRECT;
  localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 20 + 200;
  // longest wait for any single handshake
  localparam int HS_LIMIT       = 16;
  // direct register keeps 22 bits
  localparam logic [31:0] DIRECT_MASK = (32'd1 << cond_pkg::COND_W) - 32'd1;

  typedef enum logic [1:0] {
    OP_WRITE,
    OP_READ,
    OP_DIRECT
  } op_e;

  typedef struct packed {
    op_e                    op;
    regmap_pkg::axil_addr_t addr;
    regmap_pkg::axil_data_t data;
    regmap_pkg::axil_data_t exp_data;
    regmap_pkg::axil_resp_e exp_resp;
  } test_t;

  logic                  clk;
  logic                  reset;
  regmap_pkg::axil_req_t axil_req;
  regmap_pkg::axil_rsp_t axil_rsp;
  cond_pkg::cond_out_t   cond_out;

  test_t               tests [NUM_ENTRIES];
  logic [31:0]         lcg_state = 32'h1c70;
  int                  cycle_count = 0;
  logic [7:0]          prev_monitor;
  logic                cur_led;
  int                  run_len;
  int                  runs_done;

  cond_ctrl_top cond_ctrl_top_i (
    .clk      (clk),
    .reset    (reset),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .cond_out (cond_out)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // failure handling and compare tasks

  task automatic stop_run();
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_cond(input string name, input cond_pkg::cond_out_t got,
                            input cond_pkg::cond_out_t exp);
    if (got !== exp)
    begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_data(input string name, input regmap_pkg::axil_data_t got,
                            input regmap_pkg::axil_data_t exp);
    if (got !== exp)
    begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_resp(input string name, input regmap_pkg::axil_resp_e got,
                            input regmap_pkg::axil_resp_e exp);
    if (got !== exp)
    begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  // run lengths of the capacitor phases
  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
    begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  // run limit
  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_run();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic test_t make_test(input op_e op, input regmap_pkg::axil_addr_t addr,
                                      input regmap_pkg::axil_data_t data,
                                      input regmap_pkg::axil_data_t exp_data,
                                      input regmap_pkg::axil_resp_e exp_resp);
    test_t t;
    t.op       = op;
    t.addr     = addr;
    t.data     = data;
    t.exp_data = exp_data;
    t.exp_resp = exp_resp;
    return t;
  endfunction

  // counter on monitor and led from one counter bit with the muxes off
  function automatic cond_pkg::cond_out_t pattern_expect(input logic [7:0] monitor);
    cond_pkg::cond_out_t c;
    c         = '0;
    c.monitor = monitor;
    c.led0    = monitor[cond_pkg::PATTERN_LED_BIT];
    return c;
  endfunction

  // ground while led is low and dcv while it is high
  function automatic cond_pkg::cond_out_t cap_expect(input logic led);
    cond_pkg::cond_out_t c;
    c        = '0;
    c.himux  = cond_pkg::HIMUX_SEL_HIMUX2;
    c.himux2 = led ? cond_pkg::HIMUX2_SEL_DCV : cond_pkg::HIMUX2_SEL_GND;
    c.led0   = led;
    return c;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // address and data held until accepted, then dropped at the handshake edge
  task automatic wait_write_accept();
    int n;
    n = 0;
    @(negedge clk);
    while (!axil_rsp.awready)
    begin
      n++;
      if (n > HS_LIMIT)
      begin
        $display("write address and data were never accepted");
        stop_run();
      end
      @(negedge clk);
    end
    check_flag("axil_rsp.wready", axil_rsp.wready, 1'b1);
    @(posedge clk);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
  endtask

  task automatic wait_write_resp(input regmap_pkg::axil_resp_e exp_resp);
    int n;
    n = 0;
    @(negedge clk);
    while (!axil_rsp.bvalid)
    begin
      n++;
      if (n > HS_LIMIT)
      begin
        $display("write response never arrived");
        stop_run();
      end
      @(negedge clk);
    end
    check_resp("axil_rsp.bresp", axil_rsp.bresp, exp_resp);
    @(posedge clk);
  endtask

  task automatic bus_write(input regmap_pkg::axil_addr_t addr,
                           input regmap_pkg::axil_data_t data,
                           input regmap_pkg::axil_resp_e exp_resp);
    @(posedge clk);
    axil_req.awvalid <= 1'b1;
    axil_req.awaddr  <= addr;
    axil_req.wvalid  <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.bready  <= 1'b1;
    wait_write_accept();
    wait_write_resp(exp_resp);
  endtask

  task automatic bus_read(input regmap_pkg::axil_addr_t addr,
                          input regmap_pkg::axil_data_t exp_data,
                          input regmap_pkg::axil_resp_e exp_resp);
    int n;
    n = 0;
    @(posedge clk);
    axil_req.arvalid <= 1'b1;
    axil_req.araddr  <= addr;
    axil_req.rready  <= 1'b1;
    @(negedge clk);
    while (!axil_rsp.arready)
    begin
      n++;
      if (n > HS_LIMIT)
      begin
        $display("read address was never accepted");
        stop_run();
      end
      @(negedge clk);
    end
    @(posedge clk);
    axil_req.arvalid <= 1'b0;
    n = 0;
    @(negedge clk);
    while (!axil_rsp.rvalid)
    begin
      n++;
      if (n > HS_LIMIT)
      begin
        $display("read data never arrived");
        stop_run();
      end
      @(negedge clk);
    end
    check_data("axil_rsp.rdata", axil_rsp.rdata, exp_data);
    check_resp("axil_rsp.rresp", axil_rsp.rresp, exp_resp);
    @(posedge clk);
  endtask

  task automatic fill_tests();
    tests[0]  = make_test(OP_WRITE, regmap_pkg::REG_SCRATCH, 32'hA5C3_5A3C, '0,
                          regmap_pkg::RESP_OKAY);
    tests[1]  = make_test(OP_READ, regmap_pkg::REG_SCRATCH, '0, 32'hA5C3_5A3C,
                          regmap_pkg::RESP_OKAY);
    tests[2]  = make_test(OP_WRITE, regmap_pkg::REG_SCRATCH, 32'hFFFF_FFFF, '0,
                          regmap_pkg::RESP_OKAY);
    tests[3]  = make_test(OP_READ, regmap_pkg::REG_SCRATCH, '0, 32'hFFFF_FFFF,
                          regmap_pkg::RESP_OKAY);
    // low two bits select direct mode
    tests[4]  = make_test(OP_WRITE, regmap_pkg::REG_MODE, 32'hFFFF_FFF1, '0,
                          regmap_pkg::RESP_OKAY);
    tests[5]  = make_test(OP_READ, regmap_pkg::REG_MODE, '0, 32'h0000_0001,
                          regmap_pkg::RESP_OKAY);
    tests[6]  = make_test(OP_WRITE, regmap_pkg::REG_DIRECT, 32'hFFFF_FFFF, '0,
                          regmap_pkg::RESP_OKAY);
    tests[7]  = make_test(OP_READ, regmap_pkg::REG_DIRECT, '0, 32'h003F_FFFF,
                          regmap_pkg::RESP_OKAY);
    tests[8]  = make_test(OP_WRITE, 4'hC, 32'h1234_5678, '0, regmap_pkg::RESP_SLVERR);
    tests[9]  = make_test(OP_READ, 4'hC, '0, '0, regmap_pkg::RESP_SLVERR);
    // misaligned address decodes as unknown
    tests[10] = make_test(OP_READ, 4'h2, '0, '0, regmap_pkg::RESP_SLVERR);
    // unknown write left scratch alone
    tests[11] = make_test(OP_READ, regmap_pkg::REG_SCRATCH, '0, 32'hFFFF_FFFF,
                          regmap_pkg::RESP_OKAY);
    for (int i = NUM_FIXED; i < NUM_ENTRIES; i++)
    begin
      lcg_state = lcg_step(lcg_state);
      tests[i]  = make_test(OP_DIRECT, regmap_pkg::REG_DIRECT, lcg_state,
                            lcg_state & DIRECT_MASK, regmap_pkg::RESP_OKAY);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence

  initial
  begin
    axil_req = '0;
    reset    = 1'b1;
    fill_tests();
    wait_cycles(2);
    reset <= 1'b0;

    // reset state
    @(negedge clk);
    check_cond("cond_out", cond_out, '0);
    check_flag("axil_rsp.bvalid", axil_rsp.bvalid, 1'b0);
    check_flag("axil_rsp.rvalid", axil_rsp.rvalid, 1'b0);

    // register table where direct entries also check the output vector
    foreach (tests[i])
    begin
      case (tests[i].op)
        OP_WRITE:
          bus_write(tests[i].addr, tests[i].data, tests[i].exp_resp);
        OP_READ:
          bus_read(tests[i].addr, tests[i].exp_data, tests[i].exp_resp);
        default:
        begin
          bus_write(tests[i].addr, tests[i].data, tests[i].exp_resp);
          wait_cycles(1);
          @(negedge clk);
          check_cond("cond_out", cond_out,
                     cond_pkg::cond_out_t'(tests[i].exp_data[cond_pkg::COND_W-1:0]));
          bus_read(tests[i].addr, tests[i].exp_data, tests[i].exp_resp);
        end
      endcase
    end

    // in pattern mode monitor counts up by one per cycle
    bus_write(regmap_pkg::REG_MODE, regmap_pkg::axil_data_t'(cond_pkg::MODE_PATTERN),
              regmap_pkg::RESP_OKAY);
    wait_cycles(1);
    @(negedge clk);
    prev_monitor = cond_out.monitor;
    check_cond("cond_out", cond_out, pattern_expect(prev_monitor));
    repeat (20)
    begin
      @(negedge clk);
      prev_monitor = prev_monitor + 8'd1;
      check_cond("cond_out", cond_out, pattern_expect(prev_monitor));
    end

    // the first capacitor phase may be cut short by entry latency
    bus_write(regmap_pkg::REG_MODE, regmap_pkg::axil_data_t'(cond_pkg::MODE_ACCUM_CAP),
              regmap_pkg::RESP_OKAY);
    wait_cycles(1);
    @(negedge clk);
    check_cond("cond_out", cond_out, cap_expect(1'b0));
    cur_led   = 1'b0;
    run_len   = 1;
    runs_done = 0;
    while (runs_done < 5)
    begin
      @(negedge clk);
      check_cond("cond_out", cond_out, cap_expect(cond_out.led0));
      if (cond_out.led0 == cur_led)
        run_len++;
      else
      begin
        if (runs_done > 0)
          check_count("cap phase length", run_len, cond_pkg::CAP_PHASE_CYCLES);
        runs_done++;
        cur_led = cond_out.led0;
        run_len = 1;
      end
    end

    // bready held low with a second write waiting
    @(posedge clk);
    axil_req.awvalid <= 1'b1;
    axil_req.awaddr  <= regmap_pkg::REG_SCRATCH;
    axil_req.wvalid  <= 1'b1;
    axil_req.wdata   <= 32'h0BAD_F00D;
    axil_req.bready  <= 1'b0;
    wait_write_accept();
    axil_req.awvalid <= 1'b1;
    axil_req.awaddr  <= regmap_pkg::REG_MODE;
    axil_req.wvalid  <= 1'b1;
    axil_req.wdata   <= regmap_pkg::axil_data_t'(cond_pkg::MODE_OFF);
    repeat (5)
    begin
      @(negedge clk);
      check_flag("axil_rsp.bvalid", axil_rsp.bvalid, 1'b1);
      check_flag("axil_rsp.awready", axil_rsp.awready, 1'b0);
      check_flag("axil_rsp.wready", axil_rsp.wready, 1'b0);
    end
    @(posedge clk);
    axil_req.bready <= 1'b1;
    wait_write_resp(regmap_pkg::RESP_OKAY);
    wait_write_accept();
    wait_write_resp(regmap_pkg::RESP_OKAY);
    wait_cycles(1);
    @(negedge clk);
    check_cond("cond_out", cond_out, '0);
    bus_read(regmap_pkg::REG_SCRATCH, 32'h0BAD_F00D, regmap_pkg::RESP_OKAY);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- hw/cond_ctrl_top.sv
/*
 * conditioning output controller top level
 * register bank, pattern sources and output mode select
 */

module cond_ctrl_top (
  input  logic                  clk,
  input  logic                  reset,
  input  regmap_pkg::axil_req_t axil_req,
  output regmap_pkg::axil_rsp_t axil_rsp,
  output cond_pkg::cond_out_t   cond_out
);

  cond_pkg::mode_e     mode;
  cond_pkg::cond_out_t direct;
  cond_pkg::cond_out_t pattern;
  cond_pkg::cond_out_t cap_seq;

  //////////////////////////////////////////////////////////////////////
  // stage 1, host registers

  axil_reg_bank axil_reg_bank_i (
    .clk    (clk),
    .reset  (reset),
    .req    (axil_req),
    .rsp    (axil_rsp),
    .mode   (mode),
    .direct (direct)
  );

  // stage 2, pattern sources
  pattern_gen pattern_gen_i (
    .clk     (clk),
    .reset   (reset),
    .pattern (pattern)
  );

  cap_sequencer cap_sequencer_i (
    .clk     (clk),
    .reset   (reset),
    .mode    (mode),
    .cap_seq (cap_seq)
  );

  // stage 3, registered output
  mode_select mode_select_i (
    .clk      (clk),
    .reset    (reset),
    .mode     (mode),
    .direct   (direct),
    .pattern  (pattern),
    .cap_seq  (cap_seq),
    .cond_out (cond_out)
  );

endmodule

//--- hw/mode_select.sv
/*
 * output register
 * four way selection of the conditioning vector by mode
 */

module mode_select (
  input  logic                clk,
  input  logic                reset,
  input  cond_pkg::mode_e     mode,
  input  cond_pkg::cond_out_t direct,
  input  cond_pkg::cond_out_t pattern,
  input  cond_pkg::cond_out_t cap_seq,
  output cond_pkg::cond_out_t cond_out
);

  //////////////////////////////////////////////////////////////////////
  // source select

  cond_pkg::cond_out_t selected;

  always_comb
  begin
    case (mode)
      cond_pkg::MODE_DIRECT:    selected = direct;
      cond_pkg::MODE_PATTERN:   selected = pattern;
      cond_pkg::MODE_ACCUM_CAP: selected = cap_seq;
      // off drops every switch and the led
      default:                  selected = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // output register

  // pins come straight off flops, glitch free on a mode change
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      cond_out <= '0;
    else
      cond_out <= selected;
  end

endmodule

//--- hw/cap_sequencer.sv
/*
 * accumulation capacitor sequence source
 * alternates himux2 between ground and the dcv source,
 * led marks the charge phase
 */

module cap_sequencer (
  input  logic                clk,
  input  logic                reset,
  input  cond_pkg::mode_e     mode,
  output cond_pkg::cond_out_t cap_seq
);

  // last count of the full two phase period
  localparam logic [cond_pkg::CAP_CNT_W-1:0] LAST_CNT =
    cond_pkg::CAP_CNT_W'(2 * cond_pkg::CAP_PHASE_CYCLES - 1);
  // first count of the dcv phase
  localparam logic [cond_pkg::CAP_CNT_W-1:0] DCV_CNT =
    cond_pkg::CAP_CNT_W'(cond_pkg::CAP_PHASE_CYCLES);

  logic [cond_pkg::CAP_CNT_W-1:0] phase_cnt;
  logic                           dcv_phase;

  //////////////////////////////////////////////////////////////////////
  // phase counter

  // parked at zero outside the mode, so every entry
  // starts with a full ground phase
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      phase_cnt <= '0;
    else if (mode != cond_pkg::MODE_ACCUM_CAP)
      phase_cnt <= '0;
    else if (phase_cnt == LAST_CNT)
      phase_cnt <= '0;
    else
      phase_cnt <= phase_cnt + 1'b1;
  end

  // upper half of the period
  assign dcv_phase = (phase_cnt >= DCV_CNT);

  //////////////////////////////////////////////////////////////////////
  // output vector

  always_comb
  begin
    cap_seq = '0;

    // himux always feeds the cap via himux2
    cap_seq.himux = cond_pkg::HIMUX_SEL_HIMUX2;

    if (dcv_phase)
    begin
      // integrate the dcv source
      cap_seq.himux2 = cond_pkg::HIMUX2_SEL_DCV;
      cap_seq.led0   = 1'b1;
    end
    else
    begin
      // dump the charge to ground
      cap_seq.himux2 = cond_pkg::HIMUX2_SEL_GND;
      cap_seq.led0   = 1'b0;
    end

    // azmux, pre-charge and monitor left idle
  end

endmodule

//--- hw/pattern_gen.sv
/*
 * test pattern source
 * free running counter on the monitor port and led
 */

module pattern_gen (
  input  logic                clk,
  input  logic                reset,
  output cond_pkg::cond_out_t pattern
);

  //////////////////////////////////////////////////////////////////////
  // counter

  // wraps at 256 with no enable
  logic [7:0] count;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      count <= '0;
    else
      count <= count + 8'd1;
  end

  //////////////////////////////////////////////////////////////////////
  // output vector

  // only monitor and led move while the analog muxes stay off
  always_comb
  begin
    pattern         = '0;
    pattern.monitor = count;

    // led toggles every 8 counts
    pattern.led0    = count[cond_pkg::PATTERN_LED_BIT];
  end

endmodule

//--- hw/axil_reg_bank.sv
/*
 * AXI4-Lite register slave
 * holds the mode, direct and scratch registers
 * with separate write and read response channels
 */

module axil_reg_bank (
  input  logic                  clk,
  input  logic                  reset,
  input  regmap_pkg::axil_req_t req,
  output regmap_pkg::axil_rsp_t rsp,
  output cond_pkg::mode_e       mode,
  output cond_pkg::cond_out_t   direct
);

  // host test register
  regmap_pkg::axil_data_t scratch;

  // response channel state
  logic                   bvalid;
  logic                   rvalid;
  regmap_pkg::axil_resp_e bresp;
  regmap_pkg::axil_resp_e rresp;
  regmap_pkg::axil_data_t rdata;

  // decode
  regmap_pkg::reg_addr_e  wr_addr;
  regmap_pkg::reg_addr_e  rd_addr;
  logic                   wr_fire;
  logic                   rd_fire;
  logic                   wr_hit;
  logic                   rd_hit;
  regmap_pkg::axil_data_t rd_word;

  assign wr_addr = regmap_pkg::reg_addr_e'(req.awaddr);
  assign rd_addr = regmap_pkg::reg_addr_e'(req.araddr);

  // address and data must arrive together, one write in flight
  assign wr_fire = req.awvalid && req.wvalid && !bvalid;
  assign rd_fire = req.arvalid && !rvalid;

  //////////////////////////////////////////////////////////////////////
  // write path

  always_comb
  begin
    case (wr_addr)
      regmap_pkg::REG_MODE,
      regmap_pkg::REG_DIRECT,
      regmap_pkg::REG_SCRATCH: wr_hit = 1'b1;
      default:                 wr_hit = 1'b0;
    endcase
  end

  // whole register replaced, upper bits dropped
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      mode    <= cond_pkg::MODE_OFF;
      direct  <= '0;
      scratch <= '0;
    end
    else if (wr_fire)
    begin
      case (wr_addr)
        regmap_pkg::REG_MODE:
          mode <= cond_pkg::mode_e'(req.wdata[$bits(cond_pkg::mode_e)-1:0]);
        regmap_pkg::REG_DIRECT:
          direct <= cond_pkg::cond_out_t'(req.wdata[cond_pkg::COND_W-1:0]);
        regmap_pkg::REG_SCRATCH:
          scratch <= req.wdata;
        // unknown address, nothing changes
        default:
          ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read path

  // narrow registers zero extend
  always_comb
  begin
    rd_hit = 1'b1;
    case (rd_addr)
      regmap_pkg::REG_MODE:    rd_word = regmap_pkg::axil_data_t'(mode);
      regmap_pkg::REG_DIRECT:  rd_word = regmap_pkg::axil_data_t'(direct);
      regmap_pkg::REG_SCRATCH: rd_word = scratch;
      default:
      begin
        rd_word = '0;
        rd_hit  = 1'b0;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // response channels

  // valid holds until the host takes it
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end
    else
    begin
      if (wr_fire)
        bvalid <= 1'b1;
      else if (bvalid && req.bready)
        bvalid <= 1'b0;

      if (rd_fire)
        rvalid <= 1'b1;
      else if (rvalid && req.rready)
        rvalid <= 1'b0;
    end
  end

  // response payload, only sampled while valid is high
  always_ff @(posedge clk)
  begin
    if (wr_fire)
    begin
      if (wr_hit)
        bresp <= regmap_pkg::RESP_OKAY;
      else
        bresp <= regmap_pkg::RESP_SLVERR;
    end
    if (rd_fire)
    begin
      rdata <= rd_word;
      if (rd_hit)
        rresp <= regmap_pkg::RESP_OKAY;
      else
        rresp <= regmap_pkg::RESP_SLVERR;
    end
  end

  always_comb
  begin
    rsp.awready = wr_fire;
    rsp.wready  = wr_fire;
    rsp.bvalid  = bvalid;
    rsp.bresp   = bresp;
    rsp.arready = rd_fire;
    rsp.rvalid  = rvalid;
    rsp.rresp   = rresp;
    rsp.rdata   = rdata;
  end

endmodule

//--- hw/cond_pkg.sv
/*
 * conditioning output definitions
 * output vector layout, mode encoding,
 * analog mux select codes and capacitor sequence timing
 */

package cond_pkg;

  //////////////////////////////////////////////////////////////////////
  // output vector

  localparam int COND_W = 22;

  // each select is {en, a2, a1, a0}
  typedef struct packed {
    logic [7:0] monitor;
    logic       led0;
    logic       pc_sw_ctl;
    logic [3:0] himux2;
    logic [3:0] himux;
    logic [3:0] azmux;
  } cond_out_t;

  // source of the output vector
  typedef enum logic [1:0] {
    MODE_OFF       = 2'd0,
    MODE_DIRECT    = 2'd1,
    MODE_PATTERN   = 2'd2,
    MODE_ACCUM_CAP = 2'd3
  } mode_e;

  //////////////////////////////////////////////////////////////////////
  // mux select codes

  // himux s2, routes himux2 through to the front end
  localparam logic [3:0] HIMUX_SEL_HIMUX2 = 4'h9;
  // himux2 s4, ground, clears the charge on the cap
  localparam logic [3:0] HIMUX2_SEL_GND   = 4'hB;
  // himux2 s1, dcv source hi
  localparam logic [3:0] HIMUX2_SEL_DCV   = 4'h8;

  // sequence timing
  // one phase in clocks, short so the sequence fits a simulation
  localparam int CAP_PHASE_CYCLES = 16;
  localparam int CAP_CNT_W        = $clog2(2 * CAP_PHASE_CYCLES);

  // counter bit that drives the led in pattern mode
  localparam int PATTERN_LED_BIT  = 3;

endpackage

//--- hw/regmap_pkg.sv
/*
 * host register map for the conditioning controller
 * AXI4-Lite widths, request and response bundles,
 * register addresses and response codes
 */

package regmap_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus widths

  // byte address, 4 registers of 32 bits fit in 16 bytes
  localparam int AXIL_ADDR_W = 4;
  localparam int AXIL_DATA_W = 32;

  typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
  typedef logic [AXIL_DATA_W-1:0] axil_data_t;

  //////////////////////////////////////////////////////////////////////
  // register addresses and response codes

  // word aligned, anything else decodes as unknown
  typedef enum axil_addr_t {
    REG_MODE    = 4'h0,
    REG_DIRECT  = 4'h4,
    REG_SCRATCH = 4'h8
  } reg_addr_e;

  // exokay and decerr are never returned
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_e;

  //////////////////////////////////////////////////////////////////////
  // channel bundles

  // host side, no strobes and no prot bits
  typedef struct packed {
    logic       awvalid;
    axil_addr_t awaddr;
    logic       wvalid;
    axil_data_t wdata;
    logic       bready;
    logic       arvalid;
    axil_addr_t araddr;
    logic       rready;
  } axil_req_t;

  // device side
  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    axil_resp_e bresp;
    logic       arready;
    logic       rvalid;
    axil_resp_e rresp;
    axil_data_t rdata;
  } axil_rsp_t;

endpackage
